/* filelist.f */
rtl/rv_isa_pkg.sv
rtl/core_pkg.sv
rtl/inst_decode.sv
rtl/reg_file.sv
rtl/alu.sv
rtl/hazard_unit.sv
rtl/data_mem.sv
rtl/rv_core.sv
bench/core_checker.sv
bench/tb_top.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_top -f filelist.f -o sim_tb \
    && out=$(./obj_dir/sim_tb) \
    && echo "$out" \
    && echo "$out" | grep -qx "Simulation PASSED" \
    && exit 0 \
    || { echo "simulation did not pass"; exit 1; }

/* bench/tb_top.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_top;

    logic        clk = 1'b0;
    logic        rst_n;
    logic [31:0] imem_addr, imem_data, io_addr, io_wdata, io_rdata;
    logic        io_req, io_we, io_ack;
    logic        start, report, all_seen;
    int          errors;
    integer      seed;
    int          n_io, n_reads;
    logic [31:0] prog [0:255];
    logic [31:0] ram_init [0:255];

    always #5 clk = ~clk;

    assign imem_data = prog[imem_addr[9:2]]; // combinational fetch

    rv_core dut_i (
        .clk(clk), .rst_n(rst_n), .imem_addr(imem_addr), .imem_data(imem_data),
        .io_req(io_req), .io_we(io_we), .io_addr(io_addr), .io_wdata(io_wdata),
        .io_ack(io_ack), .io_rdata(io_rdata)
    );

    core_checker checker_i (
        .clk(clk), .rst_n(rst_n), .start(start), .report(report), .prog(prog),
        .ram_init(ram_init), .io_req(io_req), .io_ack(io_ack), .io_we(io_we),
        .io_addr(io_addr), .io_wdata(io_wdata), .all_seen(all_seen), .errors(errors)
    );

    function int pick(input int n);
        return ($random(seed) & 32'h7fff_ffff) % n;
    endfunction

    task automatic build_program();
        int          kind;
        logic [2:0]  f3;
        logic [4:0]  rd, rs1, rs2;
        logic [11:0] imm, word;
        logic [20:0] joff;
        prog[0] = {20'h00010, 5'd8, rv_isa_pkg::op_lui}; // x8 holds the I/O base
        for (int i = 1; i < 240; i++) begin
            kind = pick(10);
            rd   = 5'(1 + pick(7));
            rs1  = 5'(pick(8));
            rs2  = 5'(pick(8));
            f3   = 3'(pick(8));
            imm  = 12'($random(seed));
            word = {4'b0, 6'(pick(64)), 2'b00};
            case (kind)
                0, 1: prog[i] = {((f3 == 3'd0 || f3 == 3'd5) && pick(2) == 1) ? 7'h20 : 7'h00,
                                 rs2, rs1, f3, rd, rv_isa_pkg::op_op};
                2, 3: begin
                    if (f3 == 3'd1) imm = {7'h00, imm[4:0]};
                    else if (f3 == 3'd5) imm = {pick(2) == 1 ? 7'h20 : 7'h00, imm[4:0]};
                    prog[i] = {imm, rs1, f3, rd, rv_isa_pkg::op_opimm};
                end
                4: prog[i] = {20'($random(seed)), rd,
                              pick(2) == 1 ? rv_isa_pkg::op_lui : rv_isa_pkg::op_auipc};
                5: prog[i] = {word, 5'd0, 3'b010, rd, rv_isa_pkg::op_load};
                6: prog[i] = {word[11:5], rs2, 5'd0, 3'b010, word[4:0], rv_isa_pkg::op_store};
                7: begin
                    f3 = 3'(pick(6));
                    if (f3 >= 3'd2) f3 = f3 + 3'd2; // skip the two unused codes
                    imm = 12'(4 * (1 + pick(4)));
                    prog[i] = {1'b0, imm[10:5], rs2, rs1, f3, imm[4:1], imm[11],
                               rv_isa_pkg::op_branch};
                end
                8: begin
                    joff = 21'(4 * (1 + pick(4)));
                    if (pick(2) == 1)
                        prog[i] = {joff[20], joff[10:1], joff[11], joff[19:12], rd,
                                   rv_isa_pkg::op_jal};
                    else
                        prog[i] = {12'(i * 4) + 12'(joff), 5'd0, 3'b000, rd,
                                   rv_isa_pkg::op_jalr};
                end
                default: begin
                    n_io++;
                    if (pick(2) == 1)
                        prog[i] = {word[11:5], rs2, 5'd8, 3'b010, word[4:0],
                                   rv_isa_pkg::op_store};
                    else
                        prog[i] = {word, 5'd8, 3'b010, rd, rv_isa_pkg::op_load};
                end
            endcase
        end
        for (int k = 1; k < 8; k++) begin
            prog[239 + k] = {7'd0, 5'(k), 5'd8, 3'b010, 5'(k * 4), rv_isa_pkg::op_store};
            n_io++;
        end
        for (int i = 247; i < 256; i++) prog[i] = 32'h0000_006f;
    endtask

    // I/O responder waits a random time before each ack edge
    always begin
        @(negedge clk);
        if (io_req && !io_ack) begin
            repeat (pick(6)) @(negedge clk);
            if (!io_we) begin
                io_rdata = 32'h0000_5000 + n_reads;
                n_reads++;
            end
            io_ack = 1'b1;
            while (io_req) @(negedge clk);
            repeat (pick(6)) @(negedge clk);
            io_ack = 1'b0;
        end
    end

    initial begin
        seed     = 32'h36472902;
        rst_n    = 1'b0;
        io_ack   = 1'b0;
        io_rdata = '0;
        start    = 1'b0;
        report   = 1'b0;
        n_io     = 0;
        n_reads  = 0;
        build_program();
        for (int i = 0; i < 256; i++) begin
            ram_init[i] = {8'(i) ^ 8'h3c, ~8'(i), 8'(i) + 8'h11, 8'(i) ^ 8'ha5};
            dut_i.dmem_i.ram[i] = ram_init[i];
        end
        start = 1'b1;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        wait (all_seen);
        repeat (40) @(negedge clk); // room for a stray access
        report = 1'b1;
        #1;
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        wait (rst_n);
        #((256 * 3 + 40 * n_io) * 10);
        $display("watchdog: the core did not finish its I/O accesses in time");
        report = 1'b1;
        #1;
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* bench/core_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module core_checker (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        start,
    input  logic        report,
    input  logic [31:0] prog [0:255],
    input  logic [31:0] ram_init [0:255],
    input  logic        io_req,
    input  logic        io_ack,
    input  logic        io_we,
    input  logic [31:0] io_addr,
    input  logic [31:0] io_wdata,
    output logic        all_seen,
    output int          errors
);

    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic        exp_we [$];
    logic        exp_dump [$]; // final register dump stream
    logic        built = 1'b0;
    logic        req_q = 1'b0;
    logic        ack_q = 1'b0;
    int          n_exp = 0;
    int          seen = 0;
    int          wr_checks = 0, wr_err = 0, rd_checks = 0, rd_err = 0;
    int          dump_checks = 0, dump_err = 0, hs_err = 0, extra = 0;

    function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic cond_model(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            3'd7: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // runs the program in order and records every I/O access it makes
    task automatic build_model();
        logic [31:0] x [0:31];
        logic [31:0] ram [0:63];
        logic [31:0] pc, next, ins, a, b, imm, res, addr;
        logic        wr;
        int          reads;
        for (int i = 0; i < 32; i++) x[i] = '0;
        for (int i = 0; i < 64; i++) ram[i] = ram_init[i];
        pc = '0;
        reads = 0;
        for (int steps = 0; steps < 2000; steps++) begin
            ins = prog[pc[9:2]];
            if (ins == 32'h0000_006f) break; // jump to itself
            a    = x[ins[19:15]];
            b    = x[ins[24:20]];
            imm  = {{20{ins[31]}}, ins[31:20]};
            wr   = 1'b1;
            res  = '0;
            next = pc + 32'd4;
            case (ins[6:0])
                rv_isa_pkg::op_lui:   res = {ins[31:12], 12'b0};
                rv_isa_pkg::op_auipc: res = pc + {ins[31:12], 12'b0};
                rv_isa_pkg::op_jal: begin
                    res  = pc + 32'd4;
                    next = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
                end
                rv_isa_pkg::op_jalr: begin
                    res  = pc + 32'd4;
                    next = (a + imm) & ~32'd1;
                end
                rv_isa_pkg::op_branch: begin
                    wr = 1'b0;
                    if (cond_model(ins[14:12], a, b))
                        next = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                end
                rv_isa_pkg::op_load: begin
                    addr = a + imm;
                    if (addr >= core_pkg::io_base) begin
                        exp_addr.push_back(addr);
                        exp_we.push_back(1'b0);
                        exp_data.push_back('0);
                        exp_dump.push_back(pc >= 32'd960);
                        res = 32'h0000_5000 + reads; // responder count
                        reads++;
                    end else begin
                        res = ram[addr[7:2]];
                    end
                end
                rv_isa_pkg::op_store: begin
                    wr   = 1'b0;
                    addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                    if (addr >= core_pkg::io_base) begin
                        exp_addr.push_back(addr);
                        exp_we.push_back(1'b1);
                        exp_data.push_back(b);
                        exp_dump.push_back(pc >= 32'd960);
                    end else begin
                        ram[addr[7:2]] = b;
                    end
                end
                rv_isa_pkg::op_opimm:
                    res = alu_model(ins[14:12], ins[30] && ins[14:12] == 3'd5, a, imm);
                rv_isa_pkg::op_op: res = alu_model(ins[14:12], ins[30], a, b);
                default: wr = 1'b0;
            endcase
            if (wr && ins[11:7] != 5'd0) x[ins[11:7]] = res;
            pc = next;
        end
    endtask

    initial begin
        wait (start);
        build_model();
        n_exp = exp_addr.size();
        built = 1'b1;
    end

    assign all_seen = built && (seen == n_exp);
    assign errors   = wr_err + rd_err + dump_err + hs_err + extra + (seen != n_exp ? 1 : 0);

    task automatic compare(input string name, input logic [31:0] e, input logic [31:0] g,
                           inout int errs);
        if (e !== g) begin
            $display("CHECK FAILED at %0t ns: %s expected %h got %h", $time, name, e, g);
            errs++;
        end
    endtask

    always @(posedge clk) begin
        int err_before;
        if (rst_n && io_req && !req_q) begin
            if (ack_q) begin
                $display("%0t ns: io_req rose while io_ack was still high", $time);
                hs_err++;
            end
            if (seen >= n_exp) begin
                $display("%0t ns: extra I/O access at address %h", $time, io_addr);
                extra++;
            end else if (exp_dump[seen]) begin
                dump_checks++;
                compare("io_we", 32'(exp_we[seen]), 32'(io_we), dump_err);
                compare("io_addr", exp_addr[seen], io_addr, dump_err);
                compare("io_wdata", exp_data[seen], io_wdata, dump_err);
                seen++;
            end else if (exp_we[seen]) begin
                wr_checks++;
                err_before = wr_err;
                compare("io_we", 32'(exp_we[seen]), 32'(io_we), wr_err);
                compare("io_addr", exp_addr[seen], io_addr, wr_err);
                if (wr_err == err_before) compare("io_wdata", exp_data[seen], io_wdata, wr_err);
                seen++;
            end else begin
                rd_checks++;
                compare("io_we", 32'(exp_we[seen]), 32'(io_we), rd_err);
                compare("io_addr", exp_addr[seen], io_addr, rd_err);
                seen++;
            end
        end
        req_q <= io_req;
        ack_q <= io_ack;
    end

    always @(posedge report) begin
        $display("io_write_values: %0d checked, %0d errors", wr_checks, wr_err);
        $display("io_read_sequence: %0d checked, %0d errors", rd_checks, rd_err);
        $display("handshake_order: %0d errors, %0d extra accesses", hs_err, extra);
        $display("register_dump: %0d checked, %0d errors", dump_checks, dump_err);
        $display("transaction_count: expected %0d, seen %0d", n_exp, seen);
        $display("totals: %0d checks, %0d errors", wr_checks + rd_checks + dump_checks, errors);
    end

endmodule

`default_nettype wire

/* rtl/rv_core.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_core (
    input  logic                        clk,
    input  logic                        rst_n,
    output logic [core_pkg::xlen-1:0]   imem_addr,
    input  logic [31:0]                 imem_data,
    output logic                        io_req,
    output logic                        io_we,
    output logic [core_pkg::xlen-1:0]   io_addr,
    output logic [core_pkg::xlen-1:0]   io_wdata,
    input  logic                        io_ack,
    input  logic [core_pkg::xlen-1:0]   io_rdata
);

    logic [31:0] pc, id_pc, ex_pc, d_imm, ex_imm, rf_rdata1, rf_rdata2, ex_rdata1, ex_rdata2;
    logic [31:0] src_a, src_b, alu_a, alu_b, alu_result, target, ex_result;
    logic [31:0] mem_result, mem_store_data, dm_rdata, wb_data;
    rv_isa_pkg::inst_u id_inst;
    logic        id_valid, ex_valid, mem_valid, wb_valid;
    logic        d_reg_write, d_use_imm, d_mem_read, d_mem_write, d_branch, d_jump;
    logic        d_jalr, d_auipc, d_lui, d_use_rs1, d_use_rs2;
    logic        ex_reg_write, ex_use_imm, ex_mem_read, ex_mem_write, ex_branch, ex_jump;
    logic        ex_jalr, ex_auipc, ex_lui, ex_is_op, ex_funct7_5;
    logic [2:0]  ex_funct3, alu_f3;
    logic [4:0]  ex_rs1, ex_rs2, ex_rd, mem_rd, wb_rd;
    logic        mem_reg_write, mem_mem_read, mem_mem_write, wb_reg_write;
    logic        stall, busy, alu_taken, redirect;
    logic [1:0]  fwd_a, fwd_b;

    assign imem_addr = pc;

    inst_decode decode_i (
        .inst(id_inst), .reg_write(d_reg_write), .use_imm(d_use_imm),
        .mem_read(d_mem_read), .mem_write(d_mem_write), .branch(d_branch),
        .jump(d_jump), .jalr(d_jalr), .auipc(d_auipc), .lui(d_lui),
        .use_rs1(d_use_rs1), .use_rs2(d_use_rs2), .imm(d_imm)
    );

    reg_file regs_i (
        .clk(clk), .rst_n(rst_n), .rs1(id_inst.r_fmt.rs1), .rs2(id_inst.r_fmt.rs2),
        .rd(wb_rd), .wdata(wb_data), .we(wb_valid && wb_reg_write),
        .rdata1(rf_rdata1), .rdata2(rf_rdata2)
    );

    hazard_unit hazard_i (
        .id_rs1(id_inst.r_fmt.rs1), .id_rs2(id_inst.r_fmt.rs2),
        .id_use_rs1(id_valid && d_use_rs1), .id_use_rs2(id_valid && d_use_rs2),
        .ex_rd(ex_rd), .ex_mem_read(ex_mem_read), .ex_valid(ex_valid),
        .mem_rd(mem_rd), .mem_we(mem_valid && mem_reg_write),
        .wb_rd(wb_rd), .wb_we(wb_valid && wb_reg_write),
        .ex_rs1(ex_rs1), .ex_rs2(ex_rs2), .stall(stall), .fwd_a(fwd_a), .fwd_b(fwd_b)
    );

    assign src_a = (fwd_a == core_pkg::fwd_from_mem) ? mem_result :
                   (fwd_a == core_pkg::fwd_from_wb)  ? wb_data : ex_rdata1;
    assign src_b = (fwd_b == core_pkg::fwd_from_mem) ? mem_result :
                   (fwd_b == core_pkg::fwd_from_wb)  ? wb_data : ex_rdata2;
    assign alu_a  = ex_auipc ? ex_pc : src_a;
    assign alu_b  = ex_use_imm ? ex_imm : src_b;
    assign alu_f3 = (ex_mem_read || ex_mem_write || ex_auipc) ? 3'b000 : ex_funct3; // address add

    alu alu_i (
        .a(alu_a), .b(alu_b), .funct3(alu_f3), .funct7_5(ex_funct7_5), .is_op(ex_is_op),
        .alu_sel_b(ex_lui), .result(alu_result), .taken(alu_taken)
    );

    assign redirect  = ex_valid && (ex_jump || (ex_branch && alu_taken));
    assign target    = ex_jalr ? {alu_result[31:1], 1'b0} : ex_pc + ex_imm;
    assign ex_result = ex_jump ? ex_pc + 32'd4 : alu_result; // link value

    data_mem dmem_i (
        .clk(clk), .rst_n(rst_n), .addr(mem_result), .wdata(mem_store_data),
        .read(mem_valid && mem_mem_read), .write(mem_valid && mem_mem_write),
        .rdata(dm_rdata), .busy(busy), .io_req(io_req), .io_we(io_we),
        .io_addr(io_addr), .io_wdata(io_wdata), .io_ack(io_ack), .io_rdata(io_rdata)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc        <= '0;
            id_valid  <= 1'b0;
            ex_valid  <= 1'b0;
            mem_valid <= 1'b0;
            wb_valid  <= 1'b0;
        end else if (!busy) begin // whole pipe freezes on I/O
            if (redirect) begin
                pc       <= target;
                id_valid <= 1'b0;
            end else if (!stall) begin
                pc       <= pc + 32'd4;
                id_valid <= 1'b1;
            end
            ex_valid  <= id_valid && !stall && !redirect; // bubble or flush
            mem_valid <= ex_valid;
            wb_valid  <= mem_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!busy) begin
            if (!stall) begin
                id_inst <= imem_data;
                id_pc   <= pc;
            end
            {ex_reg_write, ex_use_imm, ex_mem_read, ex_mem_write} <=
                {d_reg_write, d_use_imm, d_mem_read, d_mem_write};
            {ex_branch, ex_jump, ex_jalr, ex_auipc, ex_lui} <=
                {d_branch, d_jump, d_jalr, d_auipc, d_lui};
            ex_is_op    <= (id_inst.r_fmt.opcode == rv_isa_pkg::op_op);
            ex_funct3   <= id_inst.r_fmt.funct3;
            ex_funct7_5 <= id_inst.r_fmt.funct7[5];
            ex_rs1      <= id_inst.r_fmt.rs1;
            ex_rs2      <= id_inst.r_fmt.rs2;
            ex_rd       <= id_inst.r_fmt.rd;
            ex_imm      <= d_imm;
            ex_pc       <= id_pc;
            ex_rdata1   <= rf_rdata1;
            ex_rdata2   <= rf_rdata2;

            mem_reg_write  <= ex_reg_write;
            mem_mem_read   <= ex_mem_read;
            mem_mem_write  <= ex_mem_write;
            mem_rd         <= ex_rd;
            mem_result     <= ex_result;
            mem_store_data <= src_b;

            wb_reg_write <= mem_reg_write;
            wb_rd        <= mem_rd;
            wb_data      <= mem_mem_read ? dm_rdata : mem_result;
        end
    end

endmodule

`default_nettype wire

/* rtl/data_mem.sv */
`timescale 1ns/1ns
`default_nettype none

module data_mem (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [core_pkg::xlen-1:0]   addr,
    input  logic [core_pkg::xlen-1:0]   wdata,
    input  logic                        read,
    input  logic                        write,
    output logic [core_pkg::xlen-1:0]   rdata,
    output logic                        busy,
    output logic                        io_req,
    output logic                        io_we,
    output logic [core_pkg::xlen-1:0]   io_addr,
    output logic [core_pkg::xlen-1:0]   io_wdata,
    input  logic                        io_ack,
    input  logic [core_pkg::xlen-1:0]   io_rdata
);

    localparam int aw = $clog2(core_pkg::dmem_words);

    logic [core_pkg::xlen-1:0] ram [0:core_pkg::dmem_words-1];
    logic [core_pkg::xlen-1:0] io_data_q;
    logic [1:0]                state;
    logic                      is_io;
    logic [aw-1:0]             word;

    assign is_io = (read || write) && (addr >= core_pkg::io_base);
    assign word  = addr[aw+1:2];

    always_ff @(posedge clk) begin
        if (write && !is_io) ram[word] <= wdata;
        if (state == core_pkg::st_wait_ack && io_ack) io_data_q <= io_rdata;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= core_pkg::st_idle;
        end else begin
            case (state)
                core_pkg::st_idle:         if (is_io) state <= core_pkg::st_wait_ack;
                core_pkg::st_wait_ack:     if (io_ack) state <= core_pkg::st_wait_release;
                core_pkg::st_wait_release: if (!io_ack) state <= core_pkg::st_done;
                default:                   state <= core_pkg::st_idle; // pipeline moves on
            endcase
        end
    end

    assign busy = (state == core_pkg::st_idle) ? is_io : (state != core_pkg::st_done);

    assign io_req   = (state == core_pkg::st_wait_ack);
    assign io_we    = write;
    assign io_addr  = addr; // held stable while busy
    assign io_wdata = wdata;

    assign rdata = is_io ? io_data_q : ram[word];

endmodule

`default_nettype wire

/* rtl/hazard_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module hazard_unit (
    input  logic [4:0] id_rs1,
    input  logic [4:0] id_rs2,
    input  logic       id_use_rs1,
    input  logic       id_use_rs2,
    input  logic [4:0] ex_rd,
    input  logic       ex_mem_read,
    input  logic       ex_valid,
    input  logic [4:0] mem_rd,
    input  logic       mem_we,
    input  logic [4:0] wb_rd,
    input  logic       wb_we,
    input  logic [4:0] ex_rs1,
    input  logic [4:0] ex_rs2,
    output logic       stall,
    output logic [1:0] fwd_a,
    output logic [1:0] fwd_b
);

    logic load_in_ex;

    assign load_in_ex = ex_valid && ex_mem_read && (ex_rd != 5'd0);

    // load data only exists after MEM, so hold ID one cycle
    assign stall = load_in_ex && ((id_use_rs1 && id_rs1 == ex_rd) ||
                                  (id_use_rs2 && id_rs2 == ex_rd));

    always_comb begin
        fwd_a = core_pkg::fwd_none;
        fwd_b = core_pkg::fwd_none;
        if (mem_we && mem_rd != 5'd0 && mem_rd == ex_rs1) begin
            fwd_a = core_pkg::fwd_from_mem; // youngest result first
        end else if (wb_we && wb_rd != 5'd0 && wb_rd == ex_rs1) begin
            fwd_a = core_pkg::fwd_from_wb;
        end
        if (mem_we && mem_rd != 5'd0 && mem_rd == ex_rs2) begin
            fwd_b = core_pkg::fwd_from_mem;
        end else if (wb_we && wb_rd != 5'd0 && wb_rd == ex_rs2) begin
            fwd_b = core_pkg::fwd_from_wb;
        end
    end

endmodule

`default_nettype wire

/* rtl/alu.sv */
`timescale 1ns/1ns
`default_nettype none

module alu (
    input  logic [core_pkg::xlen-1:0]   a,
    input  logic [core_pkg::xlen-1:0]   b,
    input  logic [2:0]                  funct3,
    input  logic                        funct7_5,
    input  logic                        is_op,
    input  logic                        alu_sel_b,
    output logic [core_pkg::xlen-1:0]   result,
    output logic                        taken
);

    logic [3:0] op;
    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (funct3)
            rv_isa_pkg::f3_add_sub: op = (is_op && funct7_5) ? core_pkg::alu_sub : core_pkg::alu_add;
            rv_isa_pkg::f3_sll:     op = core_pkg::alu_sll;
            rv_isa_pkg::f3_slt:     op = core_pkg::alu_slt;
            rv_isa_pkg::f3_sltu:    op = core_pkg::alu_sltu;
            rv_isa_pkg::f3_xor:     op = core_pkg::alu_xor;
            rv_isa_pkg::f3_srl_sra: op = funct7_5 ? core_pkg::alu_sra : core_pkg::alu_srl;
            rv_isa_pkg::f3_or:      op = core_pkg::alu_or;
            default:                op = core_pkg::alu_and;
        endcase
        if (alu_sel_b) op = core_pkg::alu_pass_b; // lui
    end

    always_comb begin
        case (op)
            core_pkg::alu_add:  result = a + b;
            core_pkg::alu_sub:  result = a - b;
            core_pkg::alu_sll:  result = a << shamt;
            core_pkg::alu_slt:  result = {31'b0, $signed(a) < $signed(b)};
            core_pkg::alu_sltu: result = {31'b0, a < b};
            core_pkg::alu_xor:  result = a ^ b;
            core_pkg::alu_srl:  result = a >> shamt;
            core_pkg::alu_sra:  result = $unsigned($signed(a) >>> shamt);
            core_pkg::alu_or:   result = a | b;
            core_pkg::alu_and:  result = a & b;
            default:            result = b;
        endcase
    end

    always_comb begin
        case (funct3)
            rv_isa_pkg::beq:  taken = (a == b);
            rv_isa_pkg::bne:  taken = (a != b);
            rv_isa_pkg::blt:  taken = ($signed(a) < $signed(b));
            rv_isa_pkg::bge:  taken = ($signed(a) >= $signed(b));
            rv_isa_pkg::bltu: taken = (a < b);
            rv_isa_pkg::bgeu: taken = (a >= b);
            default:          taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/reg_file.sv */
`timescale 1ns/1ns
`default_nettype none

module reg_file (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [4:0]                  rs1,
    input  logic [4:0]                  rs2,
    input  logic [4:0]                  rd,
    input  logic [core_pkg::xlen-1:0]   wdata,
    input  logic                        we,
    output logic [core_pkg::xlen-1:0]   rdata1,
    output logic [core_pkg::xlen-1:0]   rdata2
);

    logic [core_pkg::xlen-1:0] regs [0:31];
    logic                      wr_en;

    assign wr_en = we && (rd != 5'd0); // x0 stays zero

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[rd] <= wdata;
        end
    end

    // writeback in the same cycle wins over the stored value
    assign rdata1 = (wr_en && rd == rs1) ? wdata : regs[rs1];
    assign rdata2 = (wr_en && rd == rs2) ? wdata : regs[rs2];

endmodule

`default_nettype wire

/* rtl/inst_decode.sv */
`timescale 1ns/1ns
`default_nettype none

module inst_decode (
    input  rv_isa_pkg::inst_u           inst,
    output logic                        reg_write,
    output logic                        use_imm,
    output logic                        mem_read,
    output logic                        mem_write,
    output logic                        branch,
    output logic                        jump,
    output logic                        jalr,
    output logic                        auipc,
    output logic                        lui,
    output logic                        use_rs1,
    output logic                        use_rs2,
    output logic [core_pkg::xlen-1:0]   imm
);

    logic [core_pkg::xlen-1:0] imm_i;
    logic [core_pkg::xlen-1:0] imm_s;
    logic [core_pkg::xlen-1:0] imm_b;
    logic [core_pkg::xlen-1:0] imm_u;
    logic [core_pkg::xlen-1:0] imm_j;

    assign imm_i = {{20{inst.r_fmt.funct7[6]}}, inst.r_fmt.funct7, inst.r_fmt.rs2};
    assign imm_s = {{20{inst.s_fmt.imm_hi[6]}}, inst.s_fmt.imm_hi, inst.s_fmt.imm_lo};
    assign imm_b = {{20{inst.s_fmt.imm_hi[6]}}, inst.s_fmt.imm_lo[0],
                    inst.s_fmt.imm_hi[5:0], inst.s_fmt.imm_lo[4:1], 1'b0};
    assign imm_u = {inst.s_fmt.imm_hi, inst.s_fmt.rs2, inst.s_fmt.rs1,
                    inst.s_fmt.funct3, 12'b0};
    assign imm_j = {{12{inst.s_fmt.imm_hi[6]}}, inst.s_fmt.rs1, inst.s_fmt.funct3,
                    inst.s_fmt.rs2[0], inst.s_fmt.imm_hi[5:0], inst.s_fmt.rs2[4:1], 1'b0};

    always_comb begin
        reg_write = 1'b0;
        use_imm   = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        branch    = 1'b0;
        jump      = 1'b0;
        jalr      = 1'b0;
        auipc     = 1'b0;
        lui       = 1'b0;
        use_rs1   = 1'b0;
        use_rs2   = 1'b0;
        imm       = imm_i;
        case (inst.r_fmt.opcode)
            rv_isa_pkg::op_lui: begin
                {reg_write, use_imm, lui} = 3'b111;
                imm = imm_u;
            end
            rv_isa_pkg::op_auipc: begin
                {reg_write, use_imm, auipc} = 3'b111;
                imm = imm_u;
            end
            rv_isa_pkg::op_jal: begin
                {reg_write, jump} = 2'b11;
                imm = imm_j;
            end
            rv_isa_pkg::op_jalr: begin
                {reg_write, use_imm, jump, jalr, use_rs1} = 5'b11111;
            end
            rv_isa_pkg::op_branch: begin
                {branch, use_rs1, use_rs2} = 3'b111;
                imm = imm_b;
            end
            rv_isa_pkg::op_load: {reg_write, use_imm, mem_read, use_rs1} = 4'b1111;
            rv_isa_pkg::op_store: begin
                {use_imm, mem_write, use_rs1, use_rs2} = 4'b1111;
                imm = imm_s;
            end
            rv_isa_pkg::op_opimm: {reg_write, use_imm, use_rs1} = 3'b111;
            rv_isa_pkg::op_op: {reg_write, use_rs1, use_rs2} = 3'b111;
            default: imm = imm_i; // unknown opcode acts as a nop
        endcase
    end

endmodule

`default_nettype wire

/* rtl/core_pkg.sv */
`default_nettype none

package core_pkg;

    localparam int xlen = 32;

    localparam logic [3:0] alu_add    = 4'd0;
    localparam logic [3:0] alu_sub    = 4'd1;
    localparam logic [3:0] alu_sll    = 4'd2;
    localparam logic [3:0] alu_slt    = 4'd3;
    localparam logic [3:0] alu_sltu   = 4'd4;
    localparam logic [3:0] alu_xor    = 4'd5;
    localparam logic [3:0] alu_srl    = 4'd6;
    localparam logic [3:0] alu_sra    = 4'd7;
    localparam logic [3:0] alu_or     = 4'd8;
    localparam logic [3:0] alu_and    = 4'd9;
    localparam logic [3:0] alu_pass_b = 4'd10;

    localparam int dmem_words = 256;
    localparam logic [xlen-1:0] io_base = 32'h0001_0000;

    localparam logic [1:0] fwd_none     = 2'd0;
    localparam logic [1:0] fwd_from_mem = 2'd1;
    localparam logic [1:0] fwd_from_wb  = 2'd2;

    localparam logic [1:0] st_idle         = 2'd0;
    localparam logic [1:0] st_wait_ack     = 2'd1;
    localparam logic [1:0] st_wait_release = 2'd2;
    localparam logic [1:0] st_done         = 2'd3;

endpackage

`default_nettype wire

/* rtl/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_opimm  = 7'b0010011;
    localparam logic [6:0] op_op     = 7'b0110011;

    localparam logic [2:0] beq  = 3'b000;
    localparam logic [2:0] bne  = 3'b001;
    localparam logic [2:0] blt  = 3'b100;
    localparam logic [2:0] bge  = 3'b101;
    localparam logic [2:0] bltu = 3'b110;
    localparam logic [2:0] bgeu = 3'b111;

    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r_fmt; // also the I layout
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s_fmt; // S, B, U and J share this split
    } inst_u;

endpackage

`default_nettype wire
